/* src/gmii_beat_if.sv */
/* Packed frame beats passed from the preamble stripper to the frame buffer.
   Beats are single-cycle strobes with no ready; an error beat always closes its frame. */
interface gmii_beat_if
	import gmii_rx_pkg::*;
#(
	parameter int BEAT_BYTES = 2
);

	localparam int NBYTES_W = beat_count_width(BEAT_BYTES);

	// High for exactly one cycle per beat
	logic                    valid;
	// First received byte of the beat sits in the lowest lane
	logic [8*BEAT_BYTES-1:0] data;
	// Number of valid lanes, only short of full on a last beat
	logic [NBYTES_W-1:0]     nbytes;
	// Final beat of the frame
	logic                    last;
	// The frame is bad and must be dropped, only seen together with last
	logic                    error;

	// The stripper drives all the beat signals
	modport source (output valid, data, nbytes, last, error);

	// The buffer samples them whenever valid is high
	modport sink (input valid, data, nbytes, last, error);

endinterface

/* src/gmii_frame_buffer.sv */
/* Holds the beats of each frame until its last beat, then commits or drops it.
   Committed frames stream out whole and in order, one beat per cycle. */
module gmii_frame_buffer
	import gmii_rx_pkg::*;
#(
	parameter int BEAT_BYTES    = 2,
	parameter int BUF_ADDR_BITS = 6
)
(
	input  logic i_eth_clk,
	input  logic i_eth_sresetn,

	gmii_beat_if.sink beats,

	output logic                                    o_valid,
	output logic [8*BEAT_BYTES-1:0]                 o_data,
	output logic [beat_count_width(BEAT_BYTES)-1:0] o_nbytes,
	output logic                                    o_last
);

	localparam int NBYTES_W = beat_count_width(BEAT_BYTES);
	localparam int PTR_W    = buf_ptr_width(BUF_ADDR_BITS);
	localparam int DEPTH    = 1 << BUF_ADDR_BITS;
	localparam int DATA_W   = 8 * BEAT_BYTES;

	// One stored entry is {last, nbytes, data}
	localparam int ENTRY_W  = 1 + NBYTES_W + DATA_W;

	typedef logic [PTR_W-1:0]   buf_ptr_t;
	typedef logic [ENTRY_W-1:0] entry_t;

	entry_t mem [DEPTH];

	// Next free slot for the frame being received
	buf_ptr_t wr_ptr;
	// End of the last complete frame, reads never pass it
	buf_ptr_t commit_ptr;
	// Next entry to be read out
	buf_ptr_t rd_ptr;

	buf_ptr_t wr_next;

	// Current frame has hit a full buffer and will be dropped
	logic ovf;

	logic buf_full;
	logic wr_en;
	logic commit;
	logic drop;
	logic rd_en;

	// Entry read from memory, valid the cycle after rd_en
	entry_t rd_entry;
	logic   rd_last;

	always_comb
	begin
		wr_next  = wr_ptr + buf_ptr_t'(1);
		// One slot always stays empty so full and empty differ
		buf_full = (wr_next == rd_ptr);

		// Error beats carry nothing worth storing
		wr_en  = beats.valid && !beats.error && !ovf && !buf_full;
		commit = wr_en && beats.last;
		// Any last beat that is not committed throws the whole frame away
		drop   = beats.valid && beats.last && !wr_en;

		// Only the committed region is visible to the reader
		rd_en  = (rd_ptr != commit_ptr);
	end

	// Memory write port and registered read port
	always_ff @(posedge i_eth_clk)
	begin
		if (wr_en)
		begin
			mem[wr_ptr] <= {beats.last, beats.nbytes, beats.data};
		end
		rd_entry <= mem[rd_ptr];
	end

	always_ff @(posedge i_eth_clk)
	begin
		if (!i_eth_sresetn)
		begin
			wr_ptr     <= '0;
			commit_ptr <= '0;
			rd_ptr     <= '0;
			ovf        <= 1'b0;
			o_valid    <= 1'b0;
		end
		else
		begin
			if (wr_en)
			begin
				wr_ptr <= wr_next;
			end

			// Commit publishes every beat of the frame at once
			if (commit)
			begin
				commit_ptr <= wr_next;
			end

			// Roll back to the start of the frame
			if (drop)
			begin
				wr_ptr <= commit_ptr;
			end

			// Overflow sticks until the frame's last beat
			if (beats.valid)
			begin
				if (beats.last)
				begin
					ovf <= 1'b0;
				end
				else if (buf_full)
				begin
					ovf <= 1'b1;
				end
			end

			if (rd_en)
			begin
				rd_ptr <= rd_ptr + buf_ptr_t'(1);
			end

			// Follows the registered read by one cycle
			o_valid <= rd_en;
		end
	end

	assign rd_last  = rd_entry[ENTRY_W-1];
	assign o_data   = rd_entry[DATA_W-1:0];
	assign o_nbytes = rd_entry[DATA_W +: NBYTES_W];
	// Stale memory contents never show as last outside a valid beat
	assign o_last   = o_valid && rd_last;

endmodule

/* src/gmii_preamble_strip.sv */
/* Registers the GMII receive inputs, checks and strips the preamble and SFD,
   and packs the frame bytes that follow into beats on the beat interface. */
module gmii_preamble_strip
	import gmii_rx_pkg::*;
#(
	parameter int BEAT_BYTES = 2
)
(
	input  logic       i_eth_clk,
	input  logic       i_eth_sresetn,

	input  gmii_byte_t i_rxd,
	input  logic       i_rxdv,
	input  logic       i_rxer,

	gmii_beat_if.source beats
);

	localparam int LANE_W   = lane_index_width(BEAT_BYTES);
	localparam int NBYTES_W = beat_count_width(BEAT_BYTES);

	typedef logic [LANE_W-1:0]   lane_t;
	typedef logic [NBYTES_W-1:0] nbytes_t;

	// Index of the lane that completes a beat
	localparam lane_t LAST_LANE = lane_t'(BEAT_BYTES - 1);

	// GMII inputs after one register stage
	gmii_byte_t rx_data;
	logic       rx_dv;
	logic       rx_er;

	strip_state_t state;

	// Set once at least one good preamble byte has been seen
	logic seen_pre;

	// Lane that the next frame byte is written to
	lane_t lane;

	// Decoded events for the registered byte
	logic in_frame;
	logic take_byte;
	logic frame_end;
	logic frame_err;
	logic beat_full;

	// Input data register
	always_ff @(posedge i_eth_clk)
	begin
		rx_data <= i_rxd;
	end

	always_comb
	begin
		// Registered byte belongs to the frame body
		in_frame  = (state == output_data) && rx_dv;
		take_byte = in_frame && !rx_er;
		// The unregistered valid already shows whether another byte follows
		// so the beat holding the final byte can carry last without waiting
		frame_end = take_byte && !i_rxdv;
		frame_err = in_frame && rx_er;
		beat_full = take_byte && (lane == LAST_LANE);
	end

	// Beat payload, written lane by lane straight into the interface register
	// Lanes above nbytes on a short last beat keep stale bytes
	always_ff @(posedge i_eth_clk)
	begin
		if (take_byte)
		begin
			beats.data[lane*8 +: 8] <= rx_data;
		end
		if (take_byte || frame_err)
		begin
			beats.nbytes <= nbytes_t'(lane) + nbytes_t'(1);
		end
	end

	always_ff @(posedge i_eth_clk)
	begin
		if (!i_eth_sresetn)
		begin
			rx_dv       <= 1'b0;
			rx_er       <= 1'b0;
			state       <= wait_idle;
			seen_pre    <= 1'b0;
			lane        <= '0;
			beats.valid <= 1'b0;
			beats.last  <= 1'b0;
			beats.error <= 1'b0;
		end
		else
		begin
			rx_dv <= i_rxdv;
			rx_er <= i_rxer;

			// A beat leaves when it fills up, at frame end or on an error
			beats.valid <= beat_full || frame_end || frame_err;
			beats.last  <= frame_end || frame_err;
			beats.error <= frame_err;

			case (state)
				wait_idle:
				begin
					// Only a gap in valid can start a fresh preamble
					seen_pre <= 1'b0;
					lane     <= '0;
					if (!rx_dv)
					begin
						state <= preamble;
					end
				end

				preamble:
				begin
					lane <= '0;
					if (rx_dv)
					begin
						if (rx_er)
						begin
							state <= wait_idle;
						end
						else if (rx_data == PREAMBLE_BYTE)
						begin
							seen_pre <= 1'b1;
						end
						else if ((rx_data == SFD_BYTE) && seen_pre)
						begin
							state <= output_data;
						end
						else
						begin
							// Bad preamble byte, or an SFD with no preamble ahead of it
							state <= wait_idle;
						end
					end
					else if (seen_pre)
					begin
						// Valid dropped before the SFD arrived
						state <= wait_idle;
					end
				end

				output_data:
				begin
					if (take_byte)
					begin
						lane <= (lane == LAST_LANE) ? lane_t'(0) : lane + lane_t'(1);
					end
					// An empty frame right after the SFD also ends here
					if (frame_end || frame_err || !rx_dv)
					begin
						state <= wait_idle;
					end
				end

				default:
				begin
					state <= wait_idle;
				end
			endcase
		end
	end

endmodule

/* src/gmii_rx_mac.sv */
/* Top level of the GMII receive MAC on eth_clk, with plain ports in and out.
   Links the preamble stripper to the frame buffer over the beat interface. */
module gmii_rx_mac
	import gmii_rx_pkg::*;
#(
	parameter int BEAT_BYTES    = 2,
	parameter int BUF_ADDR_BITS = 6
)
(
	input  logic                                    eth_clk,
	input  logic                                    eth_sresetn,

	// GMII receive side
	input  gmii_byte_t                              i_rxd,
	input  logic                                    i_rxdv,
	input  logic                                    i_rxer,

	// Frame beats out, good frames only
	output logic                                    o_valid,
	output logic [8*BEAT_BYTES-1:0]                 o_data,
	output logic [beat_count_width(BEAT_BYTES)-1:0] o_nbytes,
	output logic                                    o_last
);

	// Beats from the stripper, sampled by the buffer every valid cycle
	gmii_beat_if #(
		.BEAT_BYTES (BEAT_BYTES)
	) beat_bus ();

	gmii_preamble_strip #(
		.BEAT_BYTES (BEAT_BYTES)
	) u_strip (
		.i_eth_clk     (eth_clk),
		.i_eth_sresetn (eth_sresetn),
		.i_rxd         (i_rxd),
		.i_rxdv        (i_rxdv),
		.i_rxer        (i_rxer),
		.beats         (beat_bus.source)
	);

	// Frames with an error or an overflow are dropped in here
	gmii_frame_buffer #(
		.BEAT_BYTES    (BEAT_BYTES),
		.BUF_ADDR_BITS (BUF_ADDR_BITS)
	) u_buffer (
		.i_eth_clk     (eth_clk),
		.i_eth_sresetn (eth_sresetn),
		.beats         (beat_bus.sink),
		.o_valid       (o_valid),
		.o_data        (o_data),
		.o_nbytes      (o_nbytes),
		.o_last        (o_last)
	);

endmodule

/* src/gmii_rx_pkg.sv */
/* Shared types, GMII constants and width helpers for the GMII receive MAC.
   Design files and the testbench pull these in with a wildcard import. */
package gmii_rx_pkg;

	// One byte as carried on the GMII receive data lines
	typedef logic [7:0] gmii_byte_t;

	// Every preamble byte before the delimiter must carry this value
	localparam gmii_byte_t PREAMBLE_BYTE = 8'h55;

	// The start-of-frame delimiter that ends the preamble
	localparam gmii_byte_t SFD_BYTE = 8'hD5;

	// States of the preamble stripper
	typedef enum logic [1:0]
	{
		wait_idle,
		preamble,
		output_data
	} strip_state_t;

	// Width of a byte count that runs from 1 up to beat_bytes inclusive
	function automatic int beat_count_width(input int beat_bytes);
		return $clog2(beat_bytes + 1);
	endfunction

	// Width of the lane index inside a beat, kept at one bit or more
	function automatic int lane_index_width(input int beat_bytes);
		if (beat_bytes <= 1)
		begin
			return 1;
		end
		return $clog2(beat_bytes);
	endfunction

	// Width of the frame buffer pointers for a depth of 2**addr_bits beats
	function automatic int buf_ptr_width(input int addr_bits);
		if (addr_bits < 1)
		begin
			return 1;
		end
		return addr_bits;
	endfunction

endpackage

/* tb.f */
src/gmii_rx_pkg.sv
src/gmii_beat_if.sv
src/gmii_preamble_strip.sv
src/gmii_frame_buffer.sv
src/gmii_rx_mac.sv
test/tb_gmii_frame_model.sv
test/tb_gmii_rx_mac.sv

/* test/tb_gmii_frame_model.sv */
/* Frame model for the GMII receive MAC testbench. Builds the GMII cycles of a frame
   and computes the output beats that a clean frame must give. */
package tb_gmii_frame_model;
	import gmii_rx_pkg::*;

	// One expected beat, wide enough for eight lanes
	// Lanes at or above nbytes stay zero
	typedef struct packed
	{
		logic [63:0] data;
		logic [7:0]  nbytes;
		logic        last;
	} exp_beat_t;

	typedef exp_beat_t   beat_q_t[$];
	typedef gmii_byte_t  byte_q_t[$];
	// One GMII cycle as {rxdv, rxer, rxd}
	typedef logic [9:0]  gmii_cycle_t;
	typedef gmii_cycle_t cycle_q_t[$];

	// Bytes counting up from a start value, so a misplaced byte is easy to spot
	function automatic byte_q_t counting_payload(input int len, input gmii_byte_t first);
		byte_q_t bytes;
		for (int i = 0; i < len; i++)
		begin
			bytes.push_back(first + gmii_byte_t'(i));
		end
		return bytes;
	endfunction

	// Frame generator giving preamble, SFD and payload, then idle gap cycles
	// bad_pre picks a preamble byte to corrupt and err_pos a payload byte with rxer set
	// Without the SFD the frame stops right after the preamble
	function automatic cycle_q_t build_frame_cycles(input byte_q_t payload, input int pre_len,
		input int bad_pre, input bit with_sfd, input int err_pos, input int gap);
		cycle_q_t cycles;
		for (int i = 0; i < pre_len; i++)
		begin
			cycles.push_back({2'b10, (i == bad_pre) ? 8'h57 : PREAMBLE_BYTE});
		end
		if (with_sfd)
		begin
			cycles.push_back({2'b10, SFD_BYTE});
			foreach (payload[i])
			begin
				cycles.push_back({1'b1, (i == err_pos), payload[i]});
			end
		end
		// Idle means valid and error both low
		for (int i = 0; i < gap; i++)
		begin
			cycles.push_back(10'h000);
		end
		return cycles;
	endfunction

	// Reference model of the beat packing
	// Bytes fill lanes low first and a beat closes every beat_bytes bytes
	// The final beat closes early and its count is whatever is left over
	function automatic beat_q_t expected_beats(input byte_q_t payload, input int beat_bytes);
		beat_q_t   beats;
		exp_beat_t cur;
		int        lane;
		cur = '0;
		foreach (payload[i])
		begin
			lane = i % beat_bytes;
			cur.data[lane*8 +: 8] = payload[i];
			if ((lane == beat_bytes - 1) || (i == payload.size() - 1))
			begin
				cur.nbytes = 8'(lane + 1);
				cur.last   = (i == payload.size() - 1);
				beats.push_back(cur);
				cur = '0;
			end
		end
		return beats;
	endfunction

endpackage

/* test/tb_gmii_rx_mac.sv */
/* Testbench for the GMII receive MAC. Runs directed frames for errors, bad preambles
   and overflow, then a random burst, and checks every output beat against the model. */
module tb_gmii_rx_mac
	import gmii_rx_pkg::*;
	import tb_gmii_frame_model::*;
();

	localparam int BEAT_BYTES    = 2;
	localparam int BUF_ADDR_BITS = 6;
	localparam int DEPTH         = 1 << BUF_ADDR_BITS;
	localparam int DRAIN_TIMEOUT = 4000;

	logic                                    eth_clk;
	logic                                    eth_sresetn;
	gmii_byte_t                              i_rxd;
	logic                                    i_rxdv;
	logic                                    i_rxer;
	logic                                    o_valid;
	logic [8*BEAT_BYTES-1:0]                 o_data;
	logic [beat_count_width(BEAT_BYTES)-1:0] o_nbytes;
	logic                                    o_last;

	int      seed;
	string   test_name;
	// Beats still owed by the DUT, oldest first
	beat_q_t exp_q;

	gmii_rx_mac #(
		.BEAT_BYTES    (BEAT_BYTES),
		.BUF_ADDR_BITS (BUF_ADDR_BITS)
	) i_dut (
		.eth_clk     (eth_clk),
		.eth_sresetn (eth_sresetn),
		.i_rxd       (i_rxd),
		.i_rxdv      (i_rxdv),
		.i_rxer      (i_rxer),
		.o_valid     (o_valid),
		.o_data      (o_data),
		.o_nbytes    (o_nbytes),
		.o_last      (o_last)
	);

	always #2 eth_clk = ~eth_clk;

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "Run stopped in %s", test_name);
	endtask

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % 32'(n));
	endfunction

	function automatic byte_q_t random_payload(input int len);
		byte_q_t bytes;
		for (int i = 0; i < len; i++)
		begin
			bytes.push_back(gmii_byte_t'(rand_below(256)));
		end
		return bytes;
	endfunction

	// Inputs change 1 unit after the rising edge
	task automatic drive_cycles(input cycle_q_t cycles);
		foreach (cycles[i])
		begin
			@(posedge eth_clk);
			#1;
			{i_rxdv, i_rxer, i_rxd} = cycles[i];
		end
	endtask

	// Expected beats are queued before the frame goes out
	task automatic send_frame(input byte_q_t payload, input int pre_len, input int bad_pre,
		input bit with_sfd, input int err_pos, input int gap, input bit expect_out);
		beat_q_t beats;
		if (expect_out)
		begin
			beats = expected_beats(payload, BEAT_BYTES);
			foreach (beats[i])
			begin
				exp_q.push_back(beats[i]);
			end
		end
		drive_cycles(build_frame_cycles(payload, pre_len, bad_pre, with_sfd, err_pos, gap));
	endtask

	task automatic wait_drain(input int max_cycles);
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0)
		begin
			@(posedge eth_clk);
			cycles++;
			if (cycles > max_cycles)
			begin
				fail_run($sformatf("Timed out in %s with %0d beats never seen",
					test_name, exp_q.size()));
			end
		end
	endtask

	// Each output beat is compared on the falling edge where the outputs are settled
	always @(negedge eth_clk)
	begin
		exp_beat_t   want;
		logic [63:0] mask;
		logic [63:0] got;
		if (eth_sresetn && o_valid)
		begin
			assert (exp_q.size() != 0)
			else fail_run($sformatf("Output beat in %s when no frame was due", test_name));
			want = exp_q.pop_front();
			// Lanes past nbytes are don't care
			mask = '0;
			for (int l = 0; l < BEAT_BYTES; l++)
			begin
				if (l < want.nbytes)
				begin
					mask[l*8 +: 8] = 8'hFF;
				end
			end
			got = 64'(o_data) & mask;
			assert ((got == want.data) && (o_nbytes == want.nbytes) && (o_last == want.last))
			else fail_run($sformatf(
				"MISMATCH %s expected data %h nbytes %0d last %0b actual data %h nbytes %0d last %0b",
				test_name, want.data, want.nbytes, want.last, got, o_nbytes, o_last));
		end
	end

	initial
	begin
		int len;
		int gap;
		eth_clk     = 1'b0;
		eth_sresetn = 1'b0;
		i_rxd       = '0;
		i_rxdv      = 1'b0;
		i_rxer      = 1'b0;
		seed        = 32'h4c2a_1b43;
		test_name   = "reset";
		repeat (8) @(posedge eth_clk);
		#1;
		eth_sresetn = 1'b1;

		test_name = "full_beats";
		send_frame(counting_payload(20 * BEAT_BYTES, 8'h10), 7, -1, 1'b1, -1, 4, 1'b1);
		wait_drain(DRAIN_TIMEOUT);

		test_name = "partial_last";
		send_frame(counting_payload(37, 8'hA0), 7, -1, 1'b1, -1, 4, 1'b1);
		wait_drain(DRAIN_TIMEOUT);

		// Stray beats from a dropped frame would collide with the clean one after it
		test_name = "rxer_drop";
		send_frame(counting_payload(30, 8'h40), 7, -1, 1'b1, 12, 4, 1'b0);
		send_frame(counting_payload(25, 8'h80), 7, -1, 1'b1, -1, 4, 1'b1);
		wait_drain(DRAIN_TIMEOUT);

		test_name = "bad_preamble";
		send_frame(counting_payload(20, 8'h20), 7, 3, 1'b1, -1, 4, 1'b0);
		send_frame(counting_payload(21, 8'h60), 7, -1, 1'b1, -1, 4, 1'b1);
		wait_drain(DRAIN_TIMEOUT);

		test_name = "early_dv_drop";
		send_frame(counting_payload(20, 8'h30), 5, -1, 1'b0, -1, 4, 1'b0);
		// The aborted preamble must not count for an SFD that arrives on its own
		send_frame(counting_payload(18, 8'h50), 0, -1, 1'b1, -1, 4, 1'b0);
		// A single preamble byte ahead of the SFD is still a valid frame
		send_frame(counting_payload(19, 8'h90), 1, -1, 1'b1, -1, 4, 1'b1);
		wait_drain(DRAIN_TIMEOUT);

		test_name = "overflow_drop";
		send_frame(counting_payload(DEPTH * BEAT_BYTES + 9, 8'h00), 7, -1, 1'b1, -1, 4, 1'b0);
		send_frame(counting_payload(15, 8'hC0), 7, -1, 1'b1, -1, 4, 1'b1);
		wait_drain(DRAIN_TIMEOUT);

		test_name = "random_burst";
		for (int f = 0; f < 40; f++)
		begin
			len = 1 + rand_below((DEPTH / 2) * BEAT_BYTES);
			gap = 1 + rand_below(3);
			send_frame(random_payload(len), 7, -1, 1'b1, -1, gap, 1'b1);
		end
		wait_drain(DRAIN_TIMEOUT);

		// Quiet time so a late unexpected beat is still caught
		repeat (20) @(posedge eth_clk);
		if (exp_q.size() == 0)
		begin
			$display("=== PASS ===");
			$finish;
		end
		else
		begin
			fail_run($sformatf("%0d expected beats were left over", exp_q.size()));
		end
	end

endmodule
